// ==== rtl/cell_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module cell_decoder (
    input  snake_pkg::obj_code_t    obj_code,
    input  snake_pkg::grid_x_t      x,
    input  snake_pkg::grid_y_t      y,
    input  logic [8:0]              pixel_index,
    input  logic                    pixel_take,
    input  lcd_pkg::rgb565_t        lfsr_value,
    output snake_pkg::cell_window_t window,
    output lcd_pkg::rgb565_t        color,
    output logic                    body_pixel
);
    import lcd_pkg::*;
    import snake_pkg::*;

    logic [8:0] bit_sel;
    logic       apple_bit;

    // --------------------
    // cell window
    // columns run along y, pages along x
    always_comb begin
        window.start_col  = coord_t'(y) * CELL_SIZE;
        window.end_col    = (coord_t'(y) + coord_t'(1)) * CELL_SIZE;
        window.start_page = coord_t'(x) * CELL_SIZE;
        window.end_page   = (coord_t'(x) + coord_t'(1)) * CELL_SIZE;
    end

    // --------------------
    // pixel colour
    // pixel 0 sits in the top bit of the sprite
    assign bit_sel   = 9'(CELL_PIXELS - 1) - pixel_index;
    assign apple_bit = APPLE_BITMAP[bit_sel];

    always_comb begin
        case (obj_code)
            OBJ_BLANK: begin
                color = COLOR_BG;
            end
            OBJ_HEAD: begin
                color = COLOR_HEAD;
            end
            OBJ_BODY: begin
                color = lfsr_value;
            end
            OBJ_APPLE: begin
                color = apple_bit ? COLOR_APPLE : COLOR_BG;
            end
            OBJ_BORDER: begin
                color = COLOR_BORDER;
            end
            default: begin
                color = COLOR_BG;
            end
        endcase
    end

    // lfsr moves on once per finished body pixel
    assign body_pixel = pixel_take && (obj_code == OBJ_BODY);

endmodule

`default_nettype wire

// ==== rtl/lcd_bus_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

module lcd_bus_writer (
    input  logic               clk,
    input  logic               nrst,
    input  lcd_pkg::bus_word_t word,
    output lcd_pkg::lcd_byte_t d,
    output logic               dcx,
    output logic               wr
);

    // --------------------
    // bus register stage
    // d and dcx keep the last byte between writes
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            d   <= '0;
            dcx <= 1'b0;
        end else if (word.write) begin
            d   <= word.data;
            dcx <= word.dcx;
        end
    end

    // one pulse per byte
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            wr <= 1'b0;
        end else begin
            wr <= word.write;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lcd_cmd_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module lcd_cmd_sequencer (
    input  logic                    clk,
    input  logic                    nrst,
    input  lcd_pkg::update_t        mode,
    input  snake_pkg::cell_window_t window,
    input  lcd_pkg::rgb565_t        color,
    output lcd_pkg::bus_word_t      word,
    output logic [8:0]              pixel_index,
    output logic                    pixel_take,
    output logic                    cmd_finished
);
    import lcd_pkg::*;
    import snake_pkg::*;

    step_t   step;
    step_t   next_step;
    count_t  cnt;
    count_t  next_cnt;
    logic    hi_half;
    logic    next_hi;

    logic    in_pixels;
    logic    pix_done;
    count_t  pix_last;
    rgb565_t fill_color;
    rgb565_t pix_color;

    function automatic bus_word_t emit(input lcd_byte_t b, input logic dc);
        emit = '{data: b, dcx: dc, write: 1'b1};
    endfunction

    // --------------------
    // pixel phase of either script
    assign in_pixels = ((mode == UPD_INIT_RUN) && (step == INIT_FILL_STEP)) ||
                       ((mode == UPD_CELL_RUN) && (step == CELL_PIX_STEP));

    // black band first, background below it
    assign fill_color = (cnt < count_t'(TOP_BAND_PIXELS)) ? rgb565_t'(0) : COLOR_BG;
    assign pix_color  = (mode == UPD_INIT_RUN) ? fill_color : color;
    assign pix_last   = (mode == UPD_INIT_RUN) ? count_t'(FILL_PIXELS - 1)
                                               : count_t'(CELL_PIXELS - 1);
    assign pix_done   = hi_half && (cnt == pix_last);

    assign pixel_index = cnt[8:0];
    assign pixel_take  = in_pixels && hi_half && (mode == UPD_CELL_RUN);

    // --------------------
    // script decode
    always_comb begin
        next_step = step;
        next_cnt  = cnt;
        next_hi   = hi_half;
        word      = '0;

        case (mode)
            UPD_INIT_RUN: begin
                next_step = step + step_t'(1);
                case (step)
                    5'd0: begin
                        word = emit(CMD_SWRESET, 1'b0);
                    end
                    INIT_WAIT_A, INIT_WAIT_B: begin
                        if (cnt == count_t'(WAIT_CYCLES - 1)) begin
                            next_cnt = '0;
                        end else begin
                            next_cnt  = cnt + count_t'(1);
                            next_step = step;
                        end
                    end
                    5'd2: begin
                        word = emit(CMD_DISPOFF, 1'b0);
                    end
                    5'd3: begin
                        word = emit(CMD_COLMOD, 1'b0);
                    end
                    5'd4: begin
                        word = emit(PIX_FMT_16, 1'b1);
                    end
                    5'd5: begin
                        word = emit(CMD_SLPOUT, 1'b0);
                    end
                    5'd7: begin
                        word = emit(CMD_DISPON, 1'b0);
                    end
                    5'd8: begin
                        word = emit(CMD_CASET, 1'b0);
                    end
                    // full panel window starts at zero
                    5'd9, 5'd10, 5'd14, 5'd15: begin
                        word = emit(8'h00, 1'b1);
                    end
                    5'd11: begin
                        word = emit(LCD_WIDTH[15:8], 1'b1);
                    end
                    5'd12: begin
                        word = emit(LCD_WIDTH[7:0], 1'b1);
                    end
                    5'd13: begin
                        word = emit(CMD_PASET, 1'b0);
                    end
                    5'd16: begin
                        word = emit(LCD_HEIGHT[15:8], 1'b1);
                    end
                    5'd17: begin
                        word = emit(LCD_HEIGHT[7:0], 1'b1);
                    end
                    5'd18: begin
                        word = emit(CMD_RAMWR, 1'b0);
                    end
                    INIT_FILL_STEP: begin
                        next_step = step;
                    end
                    default: begin
                        next_step = step;
                    end
                endcase
            end
            UPD_CELL_RUN: begin
                next_step = step + step_t'(1);
                case (step)
                    5'd0: begin
                        word = emit(CMD_CASET, 1'b0);
                    end
                    5'd1: begin
                        word = emit(window.start_col[15:8], 1'b1);
                    end
                    5'd2: begin
                        word = emit(window.start_col[7:0], 1'b1);
                    end
                    5'd3: begin
                        word = emit(window.end_col[15:8], 1'b1);
                    end
                    5'd4: begin
                        word = emit(window.end_col[7:0], 1'b1);
                    end
                    5'd5: begin
                        word = emit(CMD_PASET, 1'b0);
                    end
                    5'd6: begin
                        word = emit(window.start_page[15:8], 1'b1);
                    end
                    5'd7: begin
                        word = emit(window.start_page[7:0], 1'b1);
                    end
                    5'd8: begin
                        word = emit(window.end_page[15:8], 1'b1);
                    end
                    5'd9: begin
                        word = emit(window.end_page[7:0], 1'b1);
                    end
                    5'd10: begin
                        word = emit(CMD_RAMWR, 1'b0);
                    end
                    CELL_PIX_STEP: begin
                        next_step = step;
                    end
                    default: begin
                        next_step = step;
                    end
                endcase
            end
            // rewind only once the script has ended
            UPD_INIT_DONE: begin
                if (step == INIT_FINAL_STEP) begin
                    next_step = '0;
                end
            end
            UPD_CELL_DONE: begin
                if (step == CELL_FINAL_STEP) begin
                    next_step = '0;
                end
            end
            UPD_IDLE: begin
                next_step = step;
            end
            default: begin
                next_step = step;
            end
        endcase

        // low byte then high byte, count moves on after the high byte
        if (in_pixels) begin
            word    = emit(hi_half ? pix_color[15:8] : pix_color[7:0], 1'b1);
            next_hi = ~hi_half;
            if (pix_done) begin
                next_cnt  = '0;
                next_step = step + step_t'(1);
            end else if (hi_half) begin
                next_cnt = cnt + count_t'(1);
            end
        end
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            step         <= '0;
            cnt          <= '0;
            hi_half      <= 1'b0;
            cmd_finished <= 1'b0;
        end else begin
            step         <= next_step;
            cnt          <= next_cnt;
            hi_half      <= next_hi;
            // one cycle behind the pointer so it follows the last bus write
            cmd_finished <= ((mode == UPD_INIT_RUN) && (step == INIT_FINAL_STEP)) ||
                            ((mode == UPD_CELL_RUN) && (step == CELL_FINAL_STEP));
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

    typedef logic [7:0]  lcd_byte_t;
    typedef logic [15:0] coord_t;
    typedef logic [15:0] rgb565_t;

    typedef enum logic [2:0] {
        UPD_IDLE      = 3'd0,
        UPD_INIT_RUN  = 3'd1,
        UPD_INIT_DONE = 3'd2,
        UPD_CELL_RUN  = 3'd3,
        UPD_CELL_DONE = 3'd4
    } update_t;

    // dcx low marks a command byte
    typedef struct packed {
        lcd_byte_t data;
        logic      dcx;
        logic      write;
    } bus_word_t;

    // --------------------
    // DCS command set
    localparam lcd_byte_t CMD_SWRESET = 8'h01;
    localparam lcd_byte_t CMD_SLPOUT  = 8'h11;
    localparam lcd_byte_t CMD_DISPOFF = 8'h28;
    localparam lcd_byte_t CMD_DISPON  = 8'h29;
    localparam lcd_byte_t CMD_CASET   = 8'h2A;
    localparam lcd_byte_t CMD_PASET   = 8'h2B;
    localparam lcd_byte_t CMD_RAMWR   = 8'h2C;
    localparam lcd_byte_t CMD_COLMOD  = 8'h3A;
    localparam lcd_byte_t PIX_FMT_16  = 8'h55;

    // --------------------
    // panel geometry and init timing
    localparam coord_t LCD_WIDTH       = 16'd240;
    localparam coord_t LCD_HEIGHT      = 16'd320;
    localparam int     FILL_PIXELS     = int'(LCD_WIDTH) * int'(LCD_HEIGHT);
    localparam int     WAIT_CYCLES     = 60000;
    localparam int     TOP_BAND_PIXELS = 4320;

    // wait and pixel counter, wide enough for the full fill
    localparam int CNT_W = $clog2(FILL_PIXELS);
    typedef logic [CNT_W-1:0] count_t;

    // script step pointer and the steps that do more than one byte
    typedef logic [4:0] step_t;
    localparam step_t INIT_WAIT_A     = 5'd1;
    localparam step_t INIT_WAIT_B     = 5'd6;
    localparam step_t INIT_FILL_STEP  = 5'd19;
    localparam step_t INIT_FINAL_STEP = 5'd20;
    localparam step_t CELL_PIX_STEP   = 5'd11;
    localparam step_t CELL_FINAL_STEP = 5'd12;

endpackage

`default_nettype wire

// ==== rtl/rainbow_lfsr.sv ====
`timescale 1ns/100ps
`default_nettype none

module rainbow_lfsr (
    input  logic             clk,
    input  logic             nrst,
    input  logic             step,
    output lcd_pkg::rgb565_t value
);
    import snake_pkg::*;

    logic feedback;

    // taps 16, 14, 13, 11
    assign feedback = value[15] ^ value[13] ^ value[12] ^ value[10];

    // sequence carries on across cells, only nrst reseeds it
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            value <= LFSR_SEED;
        end else if (step) begin
            value <= {value[14:0], feedback};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/snake_lcd_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module snake_lcd_top (
    input  logic                 clk,
    input  logic                 nrst,
    input  lcd_pkg::update_t     mode,
    input  snake_pkg::obj_code_t obj_code,
    input  snake_pkg::grid_x_t   x,
    input  snake_pkg::grid_y_t   y,
    output lcd_pkg::lcd_byte_t   d,
    output logic                 dcx,
    output logic                 wr,
    output logic                 cmd_finished
);
    import lcd_pkg::*;
    import snake_pkg::*;

    cell_window_t window;
    rgb565_t      color;
    rgb565_t      lfsr_value;
    logic         body_pixel;
    logic [8:0]   pixel_index;
    logic         pixel_take;
    bus_word_t    word;

    // decode
    cell_decoder cell_decoder_inst (
        .obj_code    (obj_code),
        .x           (x),
        .y           (y),
        .pixel_index (pixel_index),
        .pixel_take  (pixel_take),
        .lfsr_value  (lfsr_value),
        .window      (window),
        .color       (color),
        .body_pixel  (body_pixel)
    );

    rainbow_lfsr rainbow_lfsr_inst (
        .clk   (clk),
        .nrst  (nrst),
        .step  (body_pixel),
        .value (lfsr_value)
    );

    // execute
    lcd_cmd_sequencer lcd_cmd_sequencer_inst (
        .clk          (clk),
        .nrst         (nrst),
        .mode         (mode),
        .window       (window),
        .color        (color),
        .word         (word),
        .pixel_index  (pixel_index),
        .pixel_take   (pixel_take),
        .cmd_finished (cmd_finished)
    );

    // result
    lcd_bus_writer lcd_bus_writer_inst (
        .clk  (clk),
        .nrst (nrst),
        .word (word),
        .d    (d),
        .dcx  (dcx),
        .wr   (wr)
    );

endmodule

`default_nettype wire

// ==== rtl/snake_pkg.sv ====
`default_nettype none

package snake_pkg;

    // codes 5 to 7 are drawn as blank
    typedef enum logic [2:0] {
        OBJ_BLANK  = 3'd0,
        OBJ_HEAD   = 3'd1,
        OBJ_BODY   = 3'd2,
        OBJ_APPLE  = 3'd3,
        OBJ_BORDER = 3'd4
    } obj_code_t;

    typedef logic [3:0] grid_x_t;
    typedef logic [3:0] grid_y_t;

    typedef struct packed {
        lcd_pkg::coord_t start_col;
        lcd_pkg::coord_t end_col;
        lcd_pkg::coord_t start_page;
        lcd_pkg::coord_t end_page;
    } cell_window_t;

    localparam lcd_pkg::coord_t CELL_SIZE   = 16'd20;
    localparam int              CELL_PIXELS = 400;

    localparam lcd_pkg::rgb565_t COLOR_BG     = 16'h1408;
    localparam lcd_pkg::rgb565_t COLOR_HEAD   = 16'h901E;
    localparam lcd_pkg::rgb565_t COLOR_APPLE  = 16'h00F8;
    localparam lcd_pkg::rgb565_t COLOR_BORDER = 16'h0000;

    localparam lcd_pkg::rgb565_t LFSR_SEED = 16'hACE1;

    // --------------------
    // apple sprite, one row of 20 pixels per line, pixel 0 in the msb
    localparam logic [399:0] APPLE_BITMAP = {
        20'b00000000000110000000,
        20'b00000000001100000000,
        20'b00000000011000000000,
        20'b00000111101111100000,
        20'b00011111111111111000,
        20'b00111111111111111100,
        20'b01111111111111111110,
        20'b01111111111111111110,
        20'b11111111111111111111,
        20'b11111111111111111111,
        20'b11111111111111111111,
        20'b11111111111111111111,
        20'b01111111111111111110,
        20'b01111111111111111110,
        20'b00111111111111111100,
        20'b00111111111111111100,
        20'b00011111111111111000,
        20'b00001111110111110000,
        20'b00000111000011100000,
        20'b00000000000000000000
    };

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module snake_lcd_tb -Mdir obj_dir -f vlog.f \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vsnake_lcd_tb +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "all tests passed" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== sim/snake_lcd_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module snake_lcd_checker (
    input logic             clk,
    input logic             nrst,
    input lcd_pkg::update_t mode,
    input logic             wr,
    input logic             cmd_finished
);
    import lcd_pkg::*;

    logic quiet_mode;
    int   fail_count = 0;

    assign quiet_mode = (mode == UPD_IDLE) || (mode == UPD_INIT_DONE) ||
                        (mode == UPD_CELL_DONE);

    // --------------------
    // finished flag
    // rises only once the last byte has left the bus
    finish_after_last_byte: assert property (
        @(posedge clk) disable iff (!nrst) $rose(cmd_finished) |-> !wr
    ) else begin
        fail_count++;
        $error("cmd_finished rose while wr was high");
    end

    // --------------------
    // write strobe
    // wr trails the mode by the bus register
    no_write_when_quiet: assert property (
        @(posedge clk) disable iff (!nrst) quiet_mode |=> !wr
    ) else begin
        fail_count++;
        $error("wr high after an idle or done mode cycle");
    end

endmodule

bind snake_lcd_top snake_lcd_checker snake_lcd_checker_inst (
    .clk          (clk),
    .nrst         (nrst),
    .mode         (mode),
    .wr           (wr),
    .cmd_finished (cmd_finished)
);

`default_nettype wire

// ==== sim/snake_lcd_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module snake_lcd_tb;
    import lcd_pkg::*;
    import snake_pkg::*;

    logic       clk;
    logic       nrst;
    update_t    mode;
    obj_code_t  obj_code;
    grid_x_t    x;
    grid_y_t    y;
    lcd_byte_t  d;
    logic       dcx;
    logic       wr;
    logic       cmd_finished;

    int         cyc = 0;
    int         errors;
    int         seed;
    rgb565_t    lfsr_model;
    // {dcx, d} per written byte
    logic [8:0] rx_q[$];
    int         rx_cyc[$];
    logic [8:0] exp_q[$];

    snake_lcd_top snake_lcd_top_inst (
        .clk          (clk),
        .nrst         (nrst),
        .mode         (mode),
        .obj_code     (obj_code),
        .x            (x),
        .y            (y),
        .d            (d),
        .dcx          (dcx),
        .wr           (wr),
        .cmd_finished (cmd_finished)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // byte monitor, outputs are stable at the falling edge
    always @(negedge clk) begin
        if (wr) begin
            rx_q.push_back({dcx, d});
            rx_cyc.push_back(cyc);
        end
    end

    // --------------------
    // reference models
    function automatic rgb565_t lfsr_step(input rgb565_t s);
        // taps 16, 14, 13, 11
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [3:0] random_coord();
        return 4'($random(seed));
    endfunction

    task automatic expect_byte(input logic dc, input lcd_byte_t b);
        exp_q.push_back({dc, b});
    endtask

    task automatic add_pixel(input rgb565_t c);
        expect_byte(1'b1, c[7:0]);
        expect_byte(1'b1, c[15:8]);
    endtask

    task automatic add_address(input lcd_byte_t cmd, input coord_t first, input coord_t last);
        expect_byte(1'b0, cmd);
        expect_byte(1'b1, first[15:8]);
        expect_byte(1'b1, first[7:0]);
        expect_byte(1'b1, last[15:8]);
        expect_byte(1'b1, last[7:0]);
    endtask

    // --------------------
    // script handling
    // called 2 ns after a rising edge
    task automatic run_script(input update_t run_mode, input update_t done_mode,
                              input int limit, output int fin_cyc);
        int n;
        rx_q.delete();
        rx_cyc.delete();
        fin_cyc = -1;
        n = 0;
        mode = run_mode;
        while (fin_cyc < 0 && n < limit) begin
            @(negedge clk);
            if (cmd_finished) begin
                fin_cyc = cyc;
            end
            n++;
        end
        assert (fin_cyc >= 0) else begin
            errors++;
            $display("cmd_finished did not rise within %0d cycles", limit);
        end
        @(posedge clk);
        #2;
        mode = done_mode;
        @(posedge clk);
        #2;
        mode = UPD_IDLE;
        @(negedge clk);
        assert (!cmd_finished) else begin
            errors++;
            $display("cmd_finished stayed high after the done mode");
        end
    endtask

    task automatic compare_stream(input string what, input int fin_cyc);
        int n;
        int i;
        n = (rx_q.size() < exp_q.size()) ? rx_q.size() : exp_q.size();
        assert (rx_q.size() == exp_q.size()) else begin
            errors++;
            $display("[FAIL] %s wr count got %h expected %h", what, rx_q.size(), exp_q.size());
        end
        for (i = 0; i < n; i++) begin
            assert (rx_q[i] == exp_q[i]) else begin
                errors++;
                $display("[FAIL] %s byte %0d d got %h expected %h, dcx got %h expected %h",
                         what, i, rx_q[i][7:0], exp_q[i][7:0], rx_q[i][8], exp_q[i][8]);
            end
        end
        if (rx_cyc.size() > 0) begin
            assert (fin_cyc > rx_cyc[rx_cyc.size() - 1]) else begin
                errors++;
                $display("%s: cmd_finished did not come after the last byte", what);
            end
        end
    endtask

    // --------------------
    // directed tests
    task automatic idle_after_reset();
        int k;
        for (k = 0; k < 10; k++) begin
            @(negedge clk);
            assert (!wr && d == 8'h00 && !dcx && !cmd_finished) else begin
                errors++;
                $display("[FAIL] idle wr %h d %h dcx %h cmd_finished %h",
                         wr, d, dcx, cmd_finished);
            end
        end
    endtask

    task automatic init_sequence();
        int fin_cyc;
        int p;
        exp_q.delete();
        expect_byte(1'b0, CMD_SWRESET);
        expect_byte(1'b0, CMD_DISPOFF);
        expect_byte(1'b0, CMD_COLMOD);
        expect_byte(1'b1, PIX_FMT_16);
        expect_byte(1'b0, CMD_SLPOUT);
        expect_byte(1'b0, CMD_DISPON);
        add_address(CMD_CASET, 16'd0, LCD_WIDTH);
        add_address(CMD_PASET, 16'd0, LCD_HEIGHT);
        expect_byte(1'b0, CMD_RAMWR);
        // black band on top, background below
        for (p = 0; p < FILL_PIXELS; p++) begin
            add_pixel((p < TOP_BAND_PIXELS) ? 16'h0000 : COLOR_BG);
        end
        @(posedge clk);
        #2;
        run_script(UPD_INIT_RUN, UPD_INIT_DONE, 4 * WAIT_CYCLES + 2 * exp_q.size(), fin_cyc);
        compare_stream("init", fin_cyc);
        if (rx_cyc.size() >= 6) begin
            assert (rx_cyc[1] - rx_cyc[0] > WAIT_CYCLES) else begin
                errors++;
                $display("wait after SWRESET only %0d cycles", rx_cyc[1] - rx_cyc[0] - 1);
            end
            assert (rx_cyc[5] - rx_cyc[4] > WAIT_CYCLES) else begin
                errors++;
                $display("wait after SLPOUT only %0d cycles", rx_cyc[5] - rx_cyc[4] - 1);
            end
        end
    endtask

    task automatic draw_cell(input obj_code_t code, input grid_x_t gx, input grid_y_t gy);
        int      fin_cyc;
        int      i;
        rgb565_t c;
        exp_q.delete();
        add_address(CMD_CASET, coord_t'(gy) * CELL_SIZE, (coord_t'(gy) + 16'd1) * CELL_SIZE);
        add_address(CMD_PASET, coord_t'(gx) * CELL_SIZE, (coord_t'(gx) + 16'd1) * CELL_SIZE);
        expect_byte(1'b0, CMD_RAMWR);
        for (i = 0; i < CELL_PIXELS; i++) begin
            case (code)
                OBJ_HEAD: begin
                    c = COLOR_HEAD;
                end
                OBJ_BORDER: begin
                    c = COLOR_BORDER;
                end
                OBJ_APPLE: begin
                    c = APPLE_BITMAP[CELL_PIXELS - 1 - i] ? COLOR_APPLE : COLOR_BG;
                end
                OBJ_BODY: begin
                    c = lfsr_model;
                    lfsr_model = lfsr_step(lfsr_model);
                end
                default: begin
                    c = COLOR_BG;
                end
            endcase
            add_pixel(c);
        end
        @(posedge clk);
        #2;
        obj_code = code;
        x = gx;
        y = gy;
        run_script(UPD_CELL_RUN, UPD_CELL_DONE, 4 * exp_q.size(), fin_cyc);
        compare_stream($sformatf("cell %0d at x %0d y %0d", code, gx, gy), fin_cyc);
        // no gaps in the strobe within a cell
        for (i = 1; i < rx_cyc.size(); i++) begin
            assert (rx_cyc[i] == rx_cyc[i - 1] + 1) else begin
                errors++;
                $display("wr gap of %0d cycles before cell byte %0d",
                         rx_cyc[i] - rx_cyc[i - 1] - 1, i);
            end
        end
    endtask

    task automatic fixed_colour_cells();
        int r;
        draw_cell(OBJ_BLANK, random_coord(), random_coord());
        draw_cell(OBJ_HEAD, random_coord(), random_coord());
        draw_cell(OBJ_BORDER, random_coord(), random_coord());
        // unused codes 5 to 7
        r = ($random(seed) & 32'h7fff_ffff) % 3;
        draw_cell(obj_code_t'(3'(5 + r)), random_coord(), random_coord());
    endtask

    task automatic apple_cell();
        draw_cell(OBJ_APPLE, random_coord(), random_coord());
    endtask

    task automatic body_cells();
        draw_cell(OBJ_BODY, random_coord(), random_coord());
        draw_cell(OBJ_BODY, random_coord(), random_coord());
    endtask

    // --------------------
    // main sequence
    initial begin
        errors = 0;
        seed = 32;
        lfsr_model = LFSR_SEED;
        nrst = 1'b0;
        mode = UPD_IDLE;
        obj_code = OBJ_BLANK;
        x = '0;
        y = '0;
        repeat (3) @(posedge clk);
        #2;
        nrst = 1'b1;
        idle_after_reset();
        init_sequence();
        fixed_colour_cells();
        apple_cell();
        body_cells();
        repeat (5) @(posedge clk);
        $display("testbench errors: %0d, bound assertion errors: %0d",
                 errors, snake_lcd_top_inst.snake_lcd_checker_inst.fail_count);
        if (errors == 0 && snake_lcd_top_inst.snake_lcd_checker_inst.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // two waits, the init bytes and seven cells, with a factor of two
    initial begin
        repeat (2 * (2 * WAIT_CYCLES + 17 + 2 * FILL_PIXELS + 7 * (11 + 2 * CELL_PIXELS)))
            @(posedge clk);
        $display("watchdog expired at cycle %0d, testbench errors: %0d", cyc, errors);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/lcd_pkg.sv
rtl/snake_pkg.sv
rtl/rainbow_lfsr.sv
rtl/cell_decoder.sv
rtl/lcd_cmd_sequencer.sv
rtl/lcd_bus_writer.sv
rtl/snake_lcd_top.sv
sim/snake_lcd_checker.sv
sim/snake_lcd_tb.sv
